//--- ulpi_defines.svh
`ifndef ULPI_DEFINES_SVH
`define ULPI_DEFINES_SVH

// Upper nibble of the ULPI transmit command byte, the PID fills the low nibble
`define ULPI_TXCMD_PREFIX 4'b0100

// Upper bits of the ULPI register-write command byte, the address fills the rest
`define ULPI_REGW_PREFIX 2'b10

// Cycles the link waits for the PHY to report end of packet
`define ULPI_EOP_TIMEOUT 64

// LineState value for SE0, seen at the end of a transmitted packet
`define ULPI_LS_EOP 2'b00

`endif

//--- ulpi_pkg.sv
package ulpi_pkg;

  typedef logic [7:0] ulpi_byte_t;
  typedef logic [3:0] usb_pid_t;
  typedef logic [15:0] crc16_t;
  typedef logic [1:0] line_state_t;

  // Transmit and register-write sequencer states
  typedef enum logic [3:0] {
    IDLE,
    TXCMD,
    DATA,
    CRC_LO,
    CRC_HI,
    STOP,
    EOP_WAIT,
    REG_ADDR,
    REG_DATA,
    REG_STOP
  } tx_state_e;

  // Source of the next byte driven onto the ULPI bus
  typedef enum logic [2:0] {
    SEL_NOP,
    SEL_TXCMD,
    SEL_DATA,
    SEL_CRC_LO,
    SEL_CRC_HI,
    SEL_REG_ADDR,
    SEL_REG_DATA
  } byte_sel_e;

  typedef struct packed {
    logic       write;
    logic [5:0] addr;
    ulpi_byte_t data;
  } phy_req_t;

  typedef struct packed {
    logic busy;
    logic done;
    logic timeout;
    logic abort;
  } tx_status_t;

endpackage

//--- usb_crc16.sv
module usb_crc16
  import ulpi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       init_i,
  input  logic       update_i,
  input  ulpi_byte_t data_i,
  output crc16_t     crc_o
);

  crc16_t crc_q;

  // One byte through the reflected polynomial, LSB first
  function automatic crc16_t crc16_byte(input crc16_t crc, input ulpi_byte_t data);
    crc16_t c;
    c = crc ^ {8'h00, data};
    for (int i = 0; i < 8; i++) begin
      if (c[0]) begin
        c = (c >> 1) ^ 16'hA001;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  always_ff @(posedge clock) begin
    if (reset || init_i) begin
      crc_q <= 16'hFFFF;
    end else if (update_i) begin
      crc_q <= crc16_byte(crc_q, data_i);
    end
  end

  // Residue is inverted before it goes on the wire, low byte first
  assign crc_o = ~crc_q;

endmodule

//--- ulpi_eop_timer.sv
`include "ulpi_defines.svh"

module ulpi_eop_timer (
  input  logic clock,
  input  logic reset,
  input  logic start_i,
  input  logic clear_i,
  output logic expired_o
);

  localparam int CountWidth = $clog2(`ULPI_EOP_TIMEOUT + 1);

  logic [CountWidth-1:0] count_q;
  logic                  expired_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      count_q   <= '0;
      expired_q <= 1'b0;
    end else if (start_i) begin
      count_q   <= CountWidth'(`ULPI_EOP_TIMEOUT);
      expired_q <= 1'b0;
    end else if (clear_i) begin
      count_q   <= '0;
      expired_q <= 1'b0;
    end else begin
      // Single pulse on the step from one down to zero
      expired_q <= (count_q == CountWidth'(1));
      if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign expired_o = expired_q;

  // The FSM only starts the timer on leaving STOP and clears it from EOP_WAIT
  start_clear_exclusive : assert property (
    @(posedge clock) disable iff (reset) !(start_i && clear_i)
  ) else $error("EOP timer started and cleared together");

endmodule

//--- ulpi_tx_datapath.sv
`include "ulpi_defines.svh"

module ulpi_tx_datapath
  import ulpi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  input  ulpi_byte_t s_tdata_i,
  input  usb_pid_t   s_tpid_i,
  input  phy_req_t   phy_req_i,
  input  logic       ulpi_dir_i,

  input  byte_sel_e  byte_sel_i,
  input  logic       load_i,
  input  logic       take_i,

  output ulpi_byte_t ulpi_data_o
);

  ulpi_byte_t txcmd_byte;
  ulpi_byte_t regw_byte;
  ulpi_byte_t next_byte;
  ulpi_byte_t data_q;
  crc16_t     crc;
  logic       crc_init;

  // The PID is taken from the stream along with the command byte load
  assign txcmd_byte = {`ULPI_TXCMD_PREFIX, s_tpid_i};
  assign regw_byte  = {`ULPI_REGW_PREFIX, phy_req_i.addr};

  // New packet restarts the CRC, each accepted payload byte folds in
  assign crc_init = load_i && (byte_sel_i == SEL_TXCMD);

  usb_crc16 u_crc16 (
    .clock   (clock),
    .reset   (reset),
    .init_i  (crc_init),
    .update_i(take_i),
    .data_i  (s_tdata_i),
    .crc_o   (crc)
  );

  always_comb begin
    case (byte_sel_i)
      SEL_TXCMD:    next_byte = txcmd_byte;
      SEL_DATA:     next_byte = s_tdata_i;
      SEL_CRC_LO:   next_byte = crc[7:0];
      SEL_CRC_HI:   next_byte = crc[15:8];
      SEL_REG_ADDR: next_byte = regw_byte;
      SEL_REG_DATA: next_byte = phy_req_i.data;
      default:      next_byte = '0;
    endcase
  end

  // Output byte is held until the FSM asks for the next one
  always_ff @(posedge clock) begin
    if (reset || ulpi_dir_i) begin
      data_q <= '0;
    end else if (load_i) begin
      data_q <= next_byte;
    end
  end

  // PHY owns the bus while dir is high, so the link drives zeros
  assign ulpi_data_o = ulpi_dir_i ? '0 : data_q;

endmodule

//--- ulpi_tx_fsm.sv
`include "ulpi_defines.svh"

module ulpi_tx_fsm
  import ulpi_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  input  logic        s_tvalid_i,
  input  logic        s_tlast_i,
  input  phy_req_t    phy_req_i,

  input  logic        ulpi_dir_i,
  input  logic        ulpi_nxt_i,
  input  line_state_t line_state_i,
  input  logic        timer_expired_i,

  output logic        s_tready_o,
  output byte_sel_e   byte_sel_o,
  output logic        load_byte_o,
  output logic        take_byte_o,
  output logic        timer_start_o,
  output logic        timer_clear_o,
  output logic        ulpi_stp_o,
  output tx_status_t  status_o
);

  tx_state_e state_q;
  tx_state_e state_d;
  logic      dir_q;
  logic      last_q;
  logic      done_q;
  logic      done_d;
  logic      timeout_q;
  logic      timeout_d;
  logic      abort_q;
  logic      abort_d;
  logic      bus_free;
  logic      eop_seen;
  logic      needs_byte;

  // One turnaround cycle after the PHY releases the bus
  assign bus_free = !ulpi_dir_i && !dir_q;

  // PHY reports SE0 through an RX command while it owns the bus
  assign eop_seen = ulpi_dir_i && !ulpi_nxt_i && (line_state_i == `ULPI_LS_EOP);

  // Another payload byte is due once the held byte is accepted
  assign needs_byte = (state_q == TXCMD) || ((state_q == DATA) && !last_q);

  assign s_tready_o  = !ulpi_dir_i && ulpi_nxt_i && needs_byte;
  assign take_byte_o = s_tvalid_i && s_tready_o;

  assign ulpi_stp_o = (state_q == STOP) || (state_q == REG_STOP);

  always_comb begin
    state_d       = state_q;
    byte_sel_o    = SEL_NOP;
    load_byte_o   = 1'b0;
    timer_start_o = 1'b0;
    timer_clear_o = 1'b0;
    done_d        = 1'b0;
    timeout_d     = 1'b0;
    abort_d       = 1'b0;

    if (ulpi_dir_i && (state_q != IDLE) && (state_q != EOP_WAIT)) begin
      // PHY took the bus mid-transfer
      state_d     = IDLE;
      load_byte_o = 1'b1;
      abort_d     = 1'b1;
    end else begin
      case (state_q)
        IDLE: begin
          if (bus_free && phy_req_i.write) begin
            state_d     = REG_ADDR;
            byte_sel_o  = SEL_REG_ADDR;
            load_byte_o = 1'b1;
          end else if (bus_free && s_tvalid_i) begin
            state_d     = TXCMD;
            byte_sel_o  = SEL_TXCMD;
            load_byte_o = 1'b1;
          end
        end
        TXCMD: begin
          if (take_byte_o) begin
            state_d     = DATA;
            byte_sel_o  = SEL_DATA;
            load_byte_o = 1'b1;
          end
        end
        DATA: begin
          if (ulpi_nxt_i && last_q) begin
            state_d     = CRC_LO;
            byte_sel_o  = SEL_CRC_LO;
            load_byte_o = 1'b1;
          end else if (take_byte_o) begin
            byte_sel_o  = SEL_DATA;
            load_byte_o = 1'b1;
          end
        end
        CRC_LO: begin
          if (ulpi_nxt_i) begin
            state_d     = CRC_HI;
            byte_sel_o  = SEL_CRC_HI;
            load_byte_o = 1'b1;
          end
        end
        CRC_HI: begin
          if (ulpi_nxt_i) begin
            state_d     = STOP;
            load_byte_o = 1'b1;
          end
        end
        STOP: begin
          state_d       = EOP_WAIT;
          timer_start_o = 1'b1;
        end
        EOP_WAIT: begin
          if (eop_seen) begin
            state_d       = IDLE;
            timer_clear_o = 1'b1;
            done_d        = 1'b1;
          end else if (timer_expired_i) begin
            state_d   = IDLE;
            timeout_d = 1'b1;
          end
        end
        REG_ADDR: begin
          if (ulpi_nxt_i) begin
            state_d     = REG_DATA;
            byte_sel_o  = SEL_REG_DATA;
            load_byte_o = 1'b1;
          end
        end
        REG_DATA: begin
          // Done lines up with the stop cycle
          if (ulpi_nxt_i) begin
            state_d     = REG_STOP;
            load_byte_o = 1'b1;
            done_d      = 1'b1;
          end
        end
        default: begin
          state_d = IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q   <= IDLE;
      dir_q     <= 1'b0;
      last_q    <= 1'b0;
      done_q    <= 1'b0;
      timeout_q <= 1'b0;
      abort_q   <= 1'b0;
    end else begin
      state_q   <= state_d;
      dir_q     <= ulpi_dir_i;
      done_q    <= done_d;
      timeout_q <= timeout_d;
      abort_q   <= abort_d;
      if (take_byte_o) begin
        last_q <= s_tlast_i;
      end
    end
  end

  assign status_o.busy    = (state_q != IDLE);
  assign status_o.done    = done_q;
  assign status_o.timeout = timeout_q;
  assign status_o.abort   = abort_q;

  // Upstream must keep bytes coming until tlast, no underrun recovery
  no_underrun : assert property (
    @(posedge clock) disable iff (reset)
    (needs_byte && !ulpi_dir_i) |-> s_tvalid_i
  ) else $error("Transmit stream underrun");

  single_stop : assert property (
    @(posedge clock) disable iff (reset) ulpi_stp_o |=> !ulpi_stp_o
  ) else $error("ULPI stop held for more than one cycle");

endmodule

//--- ulpi_encoder.sv
module ulpi_encoder
  import ulpi_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  // Transmit byte stream
  input  logic        s_tvalid_i,
  output logic        s_tready_o,
  input  logic        s_tlast_i,
  input  usb_pid_t    s_tpid_i,
  input  ulpi_byte_t  s_tdata_i,

  input  phy_req_t    phy_req_i,

  // ULPI PHY side
  input  logic        ulpi_dir_i,
  input  logic        ulpi_nxt_i,
  input  line_state_t line_state_i,
  output logic        ulpi_stp_o,
  output ulpi_byte_t  ulpi_data_o,

  output tx_status_t  status_o
);

  byte_sel_e byte_sel;
  logic      load_byte;
  logic      take_byte;
  logic      timer_start;
  logic      timer_clear;
  logic      timer_expired;

  ulpi_tx_fsm u_fsm (
    .clock          (clock),
    .reset          (reset),
    .s_tvalid_i     (s_tvalid_i),
    .s_tlast_i      (s_tlast_i),
    .phy_req_i      (phy_req_i),
    .ulpi_dir_i     (ulpi_dir_i),
    .ulpi_nxt_i     (ulpi_nxt_i),
    .line_state_i   (line_state_i),
    .timer_expired_i(timer_expired),
    .s_tready_o     (s_tready_o),
    .byte_sel_o     (byte_sel),
    .load_byte_o    (load_byte),
    .take_byte_o    (take_byte),
    .timer_start_o  (timer_start),
    .timer_clear_o  (timer_clear),
    .ulpi_stp_o     (ulpi_stp_o),
    .status_o       (status_o)
  );

  ulpi_eop_timer u_eop_timer (
    .clock    (clock),
    .reset    (reset),
    .start_i  (timer_start),
    .clear_i  (timer_clear),
    .expired_o(timer_expired)
  );

  ulpi_tx_datapath u_datapath (
    .clock      (clock),
    .reset      (reset),
    .s_tdata_i  (s_tdata_i),
    .s_tpid_i   (s_tpid_i),
    .phy_req_i  (phy_req_i),
    .ulpi_dir_i (ulpi_dir_i),
    .byte_sel_i (byte_sel),
    .load_i     (load_byte),
    .take_i     (take_byte),
    .ulpi_data_o(ulpi_data_o)
  );

endmodule

//--- tb_ulpi_encoder.sv
`include "ulpi_defines.svh"

module tb_ulpi_encoder
  import ulpi_pkg::*;
();

  typedef enum logic [1:0] {
    KIND_PACKET,
    KIND_REG,
    KIND_TIMEOUT,
    KIND_ABORT
  } test_kind_e;

  // Register rows use addr and data, the other rows use pid, len and seed
  typedef struct packed {
    test_kind_e  kind;
    usb_pid_t    pid;
    logic [7:0]  len;
    logic [7:0]  seed;
    logic [5:0]  addr;
    ulpi_byte_t  data;
    line_state_t ls;
    logic [7:0]  dir_at;
  } test_entry_t;

  // Running totals kept by the bus monitor
  typedef struct packed {
    int stp;
    int done;
    int timeout;
    int abort;
    int take;
    int errors;
  } event_counts_t;

  localparam int num_tests = 8;

  logic        clock;
  logic        reset;
  logic        s_tvalid;
  logic        s_tready;
  logic        s_tlast;
  usb_pid_t    s_tpid;
  ulpi_byte_t  s_tdata;
  phy_req_t    phy_req;
  logic        ulpi_dir;
  logic        ulpi_nxt;
  line_state_t line_state;
  logic        ulpi_stp;
  ulpi_byte_t  ulpi_data;
  tx_status_t  status;

  test_entry_t   tests [num_tests];
  string         kind_names [4] = '{"packet", "register write", "timeout", "abort"};
  ulpi_byte_t    logged [$];
  event_counts_t seen = '0;
  logic          dir_prev = 1'b0;
  logic          dir_prev2 = 1'b0;
  int            cycles = 0;
  int            cycle_limit;
  int            main_errors;
  int            passed;
  int            failed;

  ulpi_encoder dut (
    .clock       (clock),
    .reset       (reset),
    .s_tvalid_i  (s_tvalid),
    .s_tready_o  (s_tready),
    .s_tlast_i   (s_tlast),
    .s_tpid_i    (s_tpid),
    .s_tdata_i   (s_tdata),
    .phy_req_i   (phy_req),
    .ulpi_dir_i  (ulpi_dir),
    .ulpi_nxt_i  (ulpi_nxt),
    .line_state_i(line_state),
    .ulpi_stp_o  (ulpi_stp),
    .ulpi_data_o (ulpi_data),
    .status_o    (status)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Run stopped at cycle %0d before the test table was finished", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic void report_mismatch(input string name, input int got, input int exp);
    $display("** Error at time %0t: %s got %0h expected %0h", $time, name, got, exp);
  endfunction

  function automatic ulpi_byte_t payload_byte(input logic [7:0] seed, input int idx);
    return seed ^ 8'(idx * 37 + 11);
  endfunction

  // USB CRC16 taken one bit at a time, LSB first, sent inverted
  function automatic crc16_t reference_crc(input ulpi_byte_t bytes [$]);
    crc16_t crc;
    logic   fb;
    crc = 16'hFFFF;
    foreach (bytes[i]) begin
      for (int b = 0; b < 8; b++) begin
        fb  = crc[0] ^ bytes[i][b];
        crc = crc >> 1;
        if (fb) begin
          crc = crc ^ 16'hA001;
        end
      end
    end
    return ~crc;
  endfunction

  function automatic event_counts_t counts_since(input event_counts_t base);
    event_counts_t d;
    d.stp     = seen.stp - base.stp;
    d.done    = seen.done - base.done;
    d.timeout = seen.timeout - base.timeout;
    d.abort   = seen.abort - base.abort;
    d.take    = seen.take - base.take;
    d.errors  = seen.errors - base.errors;
    return d;
  endfunction

  // Columns are kind, pid, len, seed, addr, data, line state, dir cycle
  function automatic void load_table();
    tests[0] = '{KIND_PACKET,  4'h3, 8'd4,  8'h11, 6'h00, 8'h00, 2'b00, 8'd0};
    tests[1] = '{KIND_REG,     4'h0, 8'd2,  8'h00, 6'h0A, 8'h55, 2'b01, 8'd0};
    tests[2] = '{KIND_PACKET,  4'hB, 8'd1,  8'h5A, 6'h00, 8'h00, 2'b00, 8'd0};
    tests[3] = '{KIND_TIMEOUT, 4'h3, 8'd3,  8'h22, 6'h00, 8'h00, 2'b01, 8'd0};
    tests[4] = '{KIND_PACKET,  4'hB, 8'd8,  8'h7C, 6'h00, 8'h00, 2'b00, 8'd0};
    tests[5] = '{KIND_ABORT,   4'h3, 8'd10, 8'h33, 6'h00, 8'h00, 2'b01, 8'd5};
    tests[6] = '{KIND_REG,     4'h0, 8'd2,  8'h00, 6'h16, 8'hA7, 2'b01, 8'd0};
    tests[7] = '{KIND_PACKET,  4'h3, 8'd16, 8'h9E, 6'h00, 8'h00, 2'b00, 8'd0};
  endfunction

  // Bus monitor, samples mid-cycle where all DUT outputs have settled
  always @(negedge clock) begin
    if (!reset) begin
      if (ulpi_nxt && !ulpi_dir && status.busy && !ulpi_stp) begin
        logged.push_back(ulpi_data);
      end
      if (s_tvalid && s_tready) begin
        seen.take++;
      end
      if (ulpi_stp) begin
        seen.stp++;
        if (ulpi_data != 8'h00) begin
          report_mismatch("ulpi_data_o in stop cycle", int'(ulpi_data), 0);
          seen.errors++;
        end
      end
      if (status.done) seen.done++;
      if (status.timeout) seen.timeout++;
      if (status.abort) seen.abort++;
      // PHY owns the bus, then one turnaround cycle before the link may start
      if ((ulpi_dir || dir_prev || dir_prev2) && ulpi_data != 8'h00) begin
        report_mismatch("ulpi_data_o near dir high", int'(ulpi_data), 0);
        seen.errors++;
      end
      if (ulpi_dir && s_tready) begin
        report_mismatch("s_tready_o while dir high", 1, 0);
        seen.errors++;
      end
    end
    dir_prev2 = dir_prev;
    dir_prev  = ulpi_dir;
  end

  task automatic run_test(input int num, input test_entry_t e);
    ulpi_byte_t    payload [$];
    ulpi_byte_t    expected [$];
    event_counts_t base;
    event_counts_t got;
    crc16_t        crc;
    int            len;
    int            log_base;
    int            busy_cycles;
    int            stp_age;
    int            dir_left;
    int            takes_at_abort;
    int            want_done;
    int            want_take;
    int            errs;
    bit            aborted;
    bit            finished;
    base = seen;
    log_base = logged.size();
    len = int'(e.len);
    busy_cycles = 0;
    stp_age = 0;
    dir_left = 0;
    takes_at_abort = 0;
    errs = 0;
    aborted = 1'b0;
    finished = 1'b0;
    @(posedge clock);
    #1;
    if (e.kind == KIND_REG) begin
      expected.push_back({`ULPI_REGW_PREFIX, e.addr});
      expected.push_back(e.data);
      phy_req = '{write: 1'b1, addr: e.addr, data: e.data};
    end else begin
      for (int i = 0; i < len; i++) begin
        payload.push_back(payload_byte(e.seed, i));
      end
      crc = reference_crc(payload);
      expected.push_back({`ULPI_TXCMD_PREFIX, e.pid});
      foreach (payload[i]) begin
        expected.push_back(payload[i]);
      end
      expected.push_back(crc[7:0]);
      expected.push_back(crc[15:8]);
      s_tpid = e.pid;
    end

    while (!finished) begin
      got = counts_since(base);
      // Source keeps valid up until its last byte is taken
      if (e.kind == KIND_REG) begin
        // A packet waits behind the register write and must not be taken
        s_tvalid = (got.done == 0);
        s_tlast  = 1'b0;
      end else if (!aborted && got.take < len) begin
        s_tvalid = 1'b1;
        s_tdata  = payload[got.take];
        s_tlast  = (got.take == len - 1);
      end else begin
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
      end
      if (got.done > 0) begin
        phy_req.write = 1'b0;
      end
      if (status.busy) begin
        busy_cycles++;
      end
      // Valid stays up in the cycle dir rises
      if (e.kind == KIND_ABORT && !aborted && busy_cycles == int'(e.dir_at)) begin
        aborted = 1'b1;
        dir_left = 3;
        takes_at_abort = got.take;
      end
      // PHY turns the bus around shortly after stp to report LineState
      if (got.stp > 0 && e.kind != KIND_REG) begin
        stp_age++;
        if (stp_age == 2) begin
          dir_left = 3;
        end
      end
      if (dir_left > 0) begin
        ulpi_dir = 1'b1;
        line_state = e.ls;
        dir_left--;
      end else begin
        ulpi_dir = 1'b0;
        line_state = 2'b01;
      end
      ulpi_nxt = 1'b0;
      if (!ulpi_dir && status.busy && !ulpi_stp &&
          (logged.size() - log_base) < expected.size()) begin
        ulpi_nxt = ($urandom % 4) != 0;
      end
      // Next entry may start while the PHY still holds the bus
      if ((got.done + got.timeout + got.abort) > 0 && !status.busy) begin
        finished = 1'b1;
      end else begin
        @(posedge clock);
        #1;
      end
    end

    got = counts_since(base);
    if (e.kind == KIND_ABORT) begin
      if (got.abort != 1) begin
        report_mismatch("status_o.abort pulses", got.abort, 1);
        errs++;
      end
      if (got.stp != 0) begin
        report_mismatch("ulpi_stp_o pulses", got.stp, 0);
        errs++;
      end
      if (got.done != 0 || got.timeout != 0) begin
        $display("** Error at time %0t: done or timeout pulsed on an aborted packet", $time);
        errs++;
      end
      if (got.take != takes_at_abort) begin
        report_mismatch("stream bytes accepted", got.take, takes_at_abort);
        errs++;
      end
    end else begin
      want_done = (e.kind == KIND_TIMEOUT) ? 0 : 1;
      want_take = (e.kind == KIND_REG) ? 0 : len;
      if ((logged.size() - log_base) != expected.size()) begin
        report_mismatch("ulpi_data_o bytes accepted", logged.size() - log_base,
                        expected.size());
        errs++;
      end else begin
        foreach (expected[i]) begin
          if (logged[log_base + i] != expected[i]) begin
            report_mismatch($sformatf("ulpi_data_o byte %0d", i),
                            int'(logged[log_base + i]), int'(expected[i]));
            errs++;
          end
        end
      end
      if (got.stp != 1) begin
        report_mismatch("ulpi_stp_o pulses", got.stp, 1);
        errs++;
      end
      if (got.done != want_done) begin
        report_mismatch("status_o.done pulses", got.done, want_done);
        errs++;
      end
      if (got.timeout != 1 - want_done) begin
        report_mismatch("status_o.timeout pulses", got.timeout, 1 - want_done);
        errs++;
      end
      if (got.abort != 0) begin
        report_mismatch("status_o.abort pulses", got.abort, 0);
        errs++;
      end
      if (got.take != want_take) begin
        report_mismatch("stream bytes accepted", got.take, want_take);
        errs++;
      end
    end
    errs += got.errors;
    main_errors += errs;
    if (errs == 0) begin
      passed++;
      $display("Test %0d %s: ok", num, kind_names[int'(e.kind)]);
    end else begin
      failed++;
      $display("Test %0d %s: %0d errors", num, kind_names[int'(e.kind)], errs);
    end
  endtask

  initial begin
    int errs;
    void'($urandom(71243));
    reset       = 1'b1;
    s_tvalid    = 1'b0;
    s_tlast     = 1'b0;
    s_tpid      = '0;
    s_tdata     = '0;
    phy_req     = '0;
    ulpi_dir    = 1'b0;
    ulpi_nxt    = 1'b0;
    line_state  = 2'b01;
    main_errors = 0;
    passed      = 0;
    failed      = 0;
    errs        = 0;
    load_table();
    cycle_limit = 1000;
    foreach (tests[i]) begin
      cycle_limit += int'(tests[i].len) * 8;
    end

    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;
    // PHY ready, yet nothing may be taken in IDLE
    ulpi_nxt = 1'b1;
    @(negedge clock);
    if (ulpi_data != 8'h00) begin
      report_mismatch("ulpi_data_o after reset", int'(ulpi_data), 0);
      errs++;
    end
    if (ulpi_stp != 1'b0 || s_tready != 1'b0) begin
      report_mismatch("ulpi_stp_o and s_tready_o after reset", int'({ulpi_stp, s_tready}), 0);
      errs++;
    end
    if (status != '0) begin
      report_mismatch("status_o after reset", int'(status), 0);
      errs++;
    end
    main_errors += errs;
    if (errs == 0) begin
      passed++;
      $display("Test 0 reset: ok");
    end else begin
      failed++;
      $display("Test 0 reset: %0d errors", errs);
    end

    for (int t = 0; t < num_tests; t++) begin
      run_test(t + 1, tests[t]);
    end

    $display("Tests %0d ok, %0d with errors, %0d errors in total", passed, failed, main_errors);
    if (main_errors == 0 && seen.errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+.
ulpi_pkg.sv
usb_crc16.sv
ulpi_eop_timer.sv
ulpi_tx_datapath.sv
ulpi_tx_fsm.sv
ulpi_encoder.sv
tb_ulpi_encoder.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and decide the result from the simulation log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ulpi_encoder -f build.f -o sim_tb \
  && ./obj_dir/sim_tb | tee sim.log \
  && grep -q "^Regression passed$" sim.log \
  && echo "Simulation run OK" \
  || { echo "Simulation run FAILED"; exit 1; }
